// ==== div_pkg.sv ====
package div_pkg;

    // ~~~~~~~~~~~~~~~~~~~~
    // Sizes
    // ~~~~~~~~~~~~~~~~~~~~

    localparam int DIV_XLEN       = 32;
    localparam int DIV_TAG_W      = 4;
    localparam int DIV_FIFO_DEPTH = 4;
    localparam int DIV_CNT_W      = 6;  // Holds the iteration count DIV_XLEN.

    localparam int DIV_FIFO_PTR_W = $clog2(DIV_FIFO_DEPTH);
    localparam int DIV_FIFO_CNT_W = $clog2(DIV_FIFO_DEPTH + 1);

    localparam logic [DIV_XLEN-1:0] DIV_ALL_ONES = {DIV_XLEN{1'b1}};
    localparam logic [DIV_XLEN-1:0] DIV_INT_MIN  = {1'b1, {(DIV_XLEN-1){1'b0}}};

    // ~~~~~~~~~~~~~~~~~~~~
    // Encodings
    // ~~~~~~~~~~~~~~~~~~~~

    typedef enum logic [1:0] {
        DIV_OP_DIV  = 2'b00,  // Signed quotient.
        DIV_OP_DIVU = 2'b01,  // Unsigned quotient.
        DIV_OP_REM  = 2'b10,  // Signed remainder.
        DIV_OP_REMU = 2'b11   // Unsigned remainder.
    } div_op_e;

    typedef enum logic [1:0] {
        DIV_CLASS_NORMAL = 2'b00,
        DIV_CLASS_ZERO   = 2'b01,  // Divisor is zero.
        DIV_CLASS_OVF    = 2'b10   // Most negative by minus one.
    } div_class_e;

    // ~~~~~~~~~~~~~~~~~~~~
    // Bundles
    // ~~~~~~~~~~~~~~~~~~~~

    // Request as seen at the unit boundary.
    typedef struct packed {
        div_op_e                op;
        logic [DIV_XLEN-1:0]    dividend;
        logic [DIV_XLEN-1:0]    divisor;
        logic [DIV_TAG_W-1:0]   tag;
    } div_req_t;

    // Prepared command, unsigned magnitudes plus what is needed to rebuild signs.
    typedef struct packed {
        logic [DIV_XLEN-1:0]    dividend_mag;
        logic [DIV_XLEN-1:0]    divisor_mag;
        logic                   quo_neg;
        logic                   rem_neg;
        logic                   want_rem;
        div_class_e             cls;
        logic [DIV_XLEN-1:0]    raw_dividend;  // Special-case results.
        logic [DIV_TAG_W-1:0]   tag;
    } div_cmd_t;

    typedef struct packed {
        logic [DIV_XLEN-1:0]    result;
        logic [DIV_TAG_W-1:0]   tag;
        div_class_e             cls;
    } div_rsp_t;

endpackage

// ==== div_operand_prep.sv ====
module div_operand_prep (
    input  logic              clk_i,
    input  logic              rst_i,
    input  logic              req_valid_i,
    input  div_pkg::div_req_t req_i,
    input  logic              fifo_full_i,
    output logic              ready_o,
    output logic              push_o,
    output div_pkg::div_cmd_t cmd_o
);

    import div_pkg::*;

    logic                is_signed;
    logic                want_rem;
    logic                dvd_neg;
    logic                dvs_neg;
    logic                accept;
    logic [DIV_XLEN-1:0] dvd_mag;
    logic [DIV_XLEN-1:0] dvs_mag;
    div_class_e          cls;
    div_cmd_t            cmd_d;

    // A push in flight may take the last free entry.
    assign ready_o = ~fifo_full_i & ~push_o;
    assign accept  = req_valid_i & ready_o;

    // ~~~~~~~~~~~~~~~~~~~~
    // Decode and classify
    // ~~~~~~~~~~~~~~~~~~~~

    always_comb begin
        is_signed = (req_i.op == DIV_OP_DIV) || (req_i.op == DIV_OP_REM);
        want_rem  = (req_i.op == DIV_OP_REM) || (req_i.op == DIV_OP_REMU);

        dvd_neg = is_signed & req_i.dividend[DIV_XLEN-1];
        dvs_neg = is_signed & req_i.divisor[DIV_XLEN-1];

        if (req_i.divisor == '0) begin
            cls = DIV_CLASS_ZERO;
        end else if (is_signed && req_i.dividend == DIV_INT_MIN
                     && req_i.divisor == DIV_ALL_ONES) begin
            cls = DIV_CLASS_OVF;
        end else begin
            cls = DIV_CLASS_NORMAL;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~
    // Magnitudes and signs
    // ~~~~~~~~~~~~~~~~~~~~

    always_comb begin
        dvd_mag = dvd_neg ? -req_i.dividend : req_i.dividend;  // INT_MIN stays 2^31.
        dvs_mag = dvs_neg ? -req_i.divisor : req_i.divisor;

        cmd_d.dividend_mag = dvd_mag;
        cmd_d.divisor_mag  = dvs_mag;
        cmd_d.quo_neg      = dvd_neg ^ dvs_neg;
        cmd_d.rem_neg      = dvd_neg;  // Remainder follows the dividend.
        cmd_d.want_rem     = want_rem;
        cmd_d.cls          = cls;
        cmd_d.raw_dividend = req_i.dividend;
        cmd_d.tag          = req_i.tag;
    end

    always_ff @(posedge clk_i) begin
        if (!rst_i) begin
            push_o <= 1'b0;
        end else begin
            push_o <= accept;
        end
    end

    always_ff @(posedge clk_i) begin
        if (accept) begin
            cmd_o <= cmd_d;
        end
    end

endmodule

// ==== div_cmd_fifo.sv ====
module div_cmd_fifo (
    input  logic              clk_i,
    input  logic              rst_i,
    input  logic              push_i,
    input  div_pkg::div_cmd_t push_data_i,
    input  logic              pop_i,
    output div_pkg::div_cmd_t pop_data_o,
    output logic              full_o,
    output logic              empty_o
);

    import div_pkg::*;

    div_cmd_t                  mem [DIV_FIFO_DEPTH];
    logic [DIV_FIFO_PTR_W-1:0] wr_ptr;
    logic [DIV_FIFO_PTR_W-1:0] rd_ptr;
    logic [DIV_FIFO_CNT_W-1:0] count;
    logic                      wr_en;
    logic                      rd_en;

    assign full_o  = (count == DIV_FIFO_CNT_W'(DIV_FIFO_DEPTH));
    assign empty_o = (count == '0);

    // Push into a full FIFO only alongside a pop.
    assign wr_en = push_i & (~full_o | pop_i);
    assign rd_en = pop_i & ~empty_o;

    assign pop_data_o = mem[rd_ptr];  // Head is always visible.

    // ~~~~~~~~~~~~~~~~~~~~
    // Pointers and level
    // ~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk_i) begin
        if (!rst_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= (wr_ptr == DIV_FIFO_PTR_W'(DIV_FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (rd_en) begin
                rd_ptr <= (rd_ptr == DIV_FIFO_PTR_W'(DIV_FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({wr_en, rd_en})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;  // Both or neither.
            endcase
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~
    // Storage
    // ~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk_i) begin
        if (wr_en) begin
            mem[wr_ptr] <= push_data_i;
        end
    end

endmodule

// ==== div_nonrestoring_core.sv ====
module div_nonrestoring_core (
    input  logic              clk_i,
    input  logic              rst_i,
    input  logic              empty_i,
    input  div_pkg::div_cmd_t cmd_i,
    output logic              pop_o,
    output logic              done_o,
    output div_pkg::div_rsp_t rsp_o
);

    import div_pkg::*;

    typedef enum logic [1:0] {
        ST_IDLE = 2'b00,
        ST_ITER = 2'b01,
        ST_CORR = 2'b10,
        ST_FIN  = 2'b11
    } state_e;

    state_e               state_q;
    state_e               state_d;
    logic [DIV_CNT_W-1:0] cnt_q;
    logic [DIV_CNT_W-1:0] cnt_d;

    // Accumulator carries one extra bit for its sign.
    logic [DIV_XLEN:0]    acc_q;
    logic [DIV_XLEN-1:0]  quo_q;
    logic [DIV_XLEN-1:0]  dvs_q;

    logic                 quo_neg_q;
    logic                 rem_neg_q;
    logic                 want_rem_q;
    div_class_e           cls_q;
    logic [DIV_XLEN-1:0]  raw_q;
    logic [DIV_TAG_W-1:0] tag_q;

    logic [DIV_XLEN:0]    acc_sh;
    logic [DIV_XLEN:0]    acc_step;
    logic [DIV_XLEN-1:0]  quo_step;
    logic [DIV_XLEN-1:0]  quo_res;
    logic [DIV_XLEN-1:0]  rem_res;

    assign pop_o  = (state_q == ST_IDLE) & ~empty_i;
    assign done_o = (state_q == ST_FIN);

    // ~~~~~~~~~~~~~~~~~~~~
    // Control
    // ~~~~~~~~~~~~~~~~~~~~

    always_comb begin
        state_d = state_q;
        cnt_d   = cnt_q;
        case (state_q)
            ST_IDLE: begin
                if (pop_o) begin
                    cnt_d   = DIV_CNT_W'(DIV_XLEN);
                    state_d = (cmd_i.cls == DIV_CLASS_NORMAL) ? ST_ITER : ST_FIN;
                end
            end
            ST_ITER: begin
                cnt_d = cnt_q - 1'b1;
                if (cnt_q == DIV_CNT_W'(1)) begin  // Last iteration.
                    state_d = ST_CORR;
                end
            end
            ST_CORR: state_d = ST_FIN;
            default: state_d = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (!rst_i) begin
            state_q <= ST_IDLE;
            cnt_q   <= '0;
        end else begin
            state_q <= state_d;
            cnt_q   <= cnt_d;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~
    // Datapath
    // ~~~~~~~~~~~~~~~~~~~~

    // One step: shift AQ left, then subtract or add back by the old sign.
    always_comb begin
        acc_sh = {acc_q[DIV_XLEN-1:0], quo_q[DIV_XLEN-1]};
        if (acc_q[DIV_XLEN]) begin
            acc_step = acc_sh + {1'b0, dvs_q};
        end else begin
            acc_step = acc_sh - {1'b0, dvs_q};
        end
        quo_step = {quo_q[DIV_XLEN-2:0], ~acc_step[DIV_XLEN]};
    end

    always_ff @(posedge clk_i) begin
        if (pop_o) begin
            acc_q      <= '0;
            quo_q      <= cmd_i.dividend_mag;
            dvs_q      <= cmd_i.divisor_mag;
            quo_neg_q  <= cmd_i.quo_neg;
            rem_neg_q  <= cmd_i.rem_neg;
            want_rem_q <= cmd_i.want_rem;
            cls_q      <= cmd_i.cls;
            raw_q      <= cmd_i.raw_dividend;
            tag_q      <= cmd_i.tag;
        end else if (state_q == ST_ITER) begin
            acc_q <= acc_step;
            quo_q <= quo_step;
        end else if (state_q == ST_CORR && acc_q[DIV_XLEN]) begin
            acc_q <= acc_q + {1'b0, dvs_q};  // Restore a negative remainder.
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~
    // Sign fixup and select
    // ~~~~~~~~~~~~~~~~~~~~

    always_comb begin
        case (cls_q)
            DIV_CLASS_ZERO: begin
                quo_res = DIV_ALL_ONES;
                rem_res = raw_q;
            end
            DIV_CLASS_OVF: begin
                quo_res = raw_q;  // INT_MIN.
                rem_res = '0;
            end
            default: begin
                quo_res = quo_neg_q ? -quo_q : quo_q;
                rem_res = rem_neg_q ? -acc_q[DIV_XLEN-1:0] : acc_q[DIV_XLEN-1:0];
            end
        endcase

        rsp_o.result = want_rem_q ? rem_res : quo_res;
        rsp_o.tag    = tag_q;
        rsp_o.cls    = cls_q;
    end

endmodule

// ==== div_unit_top.sv ====
module div_unit_top (
    input  logic              clk_i,
    input  logic              rst_i,
    input  logic              req_valid_i,
    input  div_pkg::div_req_t req_i,
    output logic              ready_o,
    output logic              done_o,
    output div_pkg::div_rsp_t rsp_o
);

    import div_pkg::*;

    logic     push;
    logic     pop;
    logic     fifo_full;
    logic     fifo_empty;
    div_cmd_t push_cmd;
    div_cmd_t head_cmd;

    // ~~~~~~~~~~~~~~~~~~~~
    // Prepare, buffer, divide
    // ~~~~~~~~~~~~~~~~~~~~

    div_operand_prep u_prep (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .req_valid_i (req_valid_i),
        .req_i       (req_i),
        .fifo_full_i (fifo_full),
        .ready_o     (ready_o),
        .push_o      (push),
        .cmd_o       (push_cmd)
    );

    div_cmd_fifo u_fifo (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .push_i      (push),
        .push_data_i (push_cmd),
        .pop_i       (pop),
        .pop_data_o  (head_cmd),
        .full_o      (fifo_full),
        .empty_o     (fifo_empty)
    );

    div_nonrestoring_core u_core (
        .clk_i   (clk_i),
        .rst_i   (rst_i),
        .empty_i (fifo_empty),
        .cmd_i   (head_cmd),
        .pop_o   (pop),
        .done_o  (done_o),
        .rsp_o   (rsp_o)
    );

endmodule

// ==== div_unit_sva.sv ====
module div_unit_sva (
    input logic              clk_i,
    input logic              rst_i,
    input logic              req_valid_i,
    input div_pkg::div_req_t req_i,
    input logic              ready_o,
    input logic              done_o,
    input div_pkg::div_rsp_t rsp_o
);

    timeunit 1ns;
    timeprecision 1ps;

    import div_pkg::*;

    localparam int LAT_SPECIAL = 3;
    localparam int LAT_NORMAL  = 36;

    typedef struct packed {
        logic [DIV_XLEN-1:0]  result;
        logic [DIV_TAG_W-1:0] tag;
        div_class_e           cls;
        logic                 alone;  // Nothing else in flight at acceptance.
        logic [31:0]          acc_cyc;
    } ref_t;

    ref_t        ref_q[$];
    ref_t        head;
    logic        head_valid;
    logic [31:0] cyc_q;
    int          err_cnt = 0;

    // RV32M results straight from the operator semantics.
    function automatic ref_t expect_rsp(div_req_t req, logic alone, logic [31:0] cyc);
        ref_t r;
        logic sgn;
        sgn       = (req.op == DIV_OP_DIV) || (req.op == DIV_OP_REM);
        r.tag     = req.tag;
        r.alone   = alone;
        r.acc_cyc = cyc;
        if (req.divisor == '0) begin
            r.cls    = DIV_CLASS_ZERO;
            r.result = (req.op == DIV_OP_DIV || req.op == DIV_OP_DIVU) ? DIV_ALL_ONES
                                                                       : req.dividend;
        end else if (sgn && req.dividend == DIV_INT_MIN && req.divisor == DIV_ALL_ONES) begin
            r.cls    = DIV_CLASS_OVF;
            r.result = (req.op == DIV_OP_DIV) ? DIV_INT_MIN : '0;
        end else begin
            r.cls = DIV_CLASS_NORMAL;
            case (req.op)
                DIV_OP_DIV:  r.result = $signed(req.dividend) / $signed(req.divisor);
                DIV_OP_REM:  r.result = $signed(req.dividend) % $signed(req.divisor);
                DIV_OP_DIVU: r.result = req.dividend / req.divisor;
                default:     r.result = req.dividend % req.divisor;
            endcase
        end
        return r;
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~
    // Reference queue
    // ~~~~~~~~~~~~~~~~~~~~

    always @(posedge clk_i) begin
        if (!rst_i) begin
            ref_q.delete();
            cyc_q      <= '0;
            head_valid <= 1'b0;
        end else begin
            cyc_q <= cyc_q + 1'b1;
            if (done_o && ref_q.size() != 0) begin
                void'(ref_q.pop_front());
            end
            if (req_valid_i && ready_o) begin
                ref_q.push_back(expect_rsp(req_i, ref_q.size() == 0, cyc_q));
            end
            head_valid <= (ref_q.size() != 0);
            if (ref_q.size() != 0) begin
                head <= ref_q[0];  // Oldest outstanding request.
            end
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~
    // Checks
    // ~~~~~~~~~~~~~~~~~~~~

    a_reset_state: assert property (@(posedge clk_i) $rose(rst_i) |-> ready_o && !done_o)
        else begin
            err_cnt = err_cnt + 1;
            $error("ERR %0t: ready_o=%b done_o=%b right after reset", $time, ready_o, done_o);
        end

    a_result: assert property (@(posedge clk_i) disable iff (!rst_i)
        done_o |-> head_valid && rsp_o.result == head.result
                   && rsp_o.tag == head.tag && rsp_o.cls == head.cls)
        else begin
            err_cnt = err_cnt + 1;
            $error("ERR %0t: got %h tag %0d, expected %h tag %0d", $time,
                   rsp_o.result, rsp_o.tag, head.result, head.tag);
        end

    a_latency: assert property (@(posedge clk_i) disable iff (!rst_i)
        done_o && head_valid && head.alone |->
            (cyc_q - head.acc_cyc) == ((head.cls == DIV_CLASS_NORMAL) ? LAT_NORMAL : LAT_SPECIAL))
        else begin
            err_cnt = err_cnt + 1;
            $error("ERR %0t: latency %0d for tag %0d", $time, cyc_q - head.acc_cyc, head.tag);
        end

    a_done_pulse: assert property (@(posedge clk_i) disable iff (!rst_i) done_o |=> !done_o)
        else begin
            err_cnt = err_cnt + 1;
            $error("ERR %0t: done_o held for more than one cycle", $time);
        end

    // Strobe while busy, dropped by the DUT.
    c_ignored: cover property (@(posedge clk_i) disable iff (!rst_i) req_valid_i && !ready_o);

endmodule

bind div_unit_top div_unit_sva u_sva (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .req_valid_i (req_valid_i),
    .req_i       (req_i),
    .ready_o     (ready_o),
    .done_o      (done_o),
    .rsp_o       (rsp_o)
);

// ==== tb_div_unit.sv ====
module tb_div_unit;

    timeunit 1ns;
    timeprecision 1ps;

    import div_pkg::*;

    localparam int N_DIRECTED = 19;
    localparam int N_BURST    = 6;
    localparam int N_RANDOM   = 24;
    localparam int N_REQ      = N_DIRECTED + N_BURST + N_RANDOM;
    localparam int WD_CYCLES  = N_REQ * 40 + 400;

    logic                 clk_i;
    logic                 rst_i;
    logic                 req_valid_i;
    div_req_t             req_i;
    logic                 ready_o;
    logic                 done_o;
    div_rsp_t             rsp_o;

    int                   seed;
    int                   sent_cnt    = 0;
    int                   rcv_cnt     = 0;
    int                   ignored_cnt = 0;
    int                   cnt_err     = 0;
    logic                 saw_full    = 1'b0;
    logic [DIV_TAG_W-1:0] next_tag;

    div_unit_top dut (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .req_valid_i (req_valid_i),
        .req_i       (req_i),
        .ready_o     (ready_o),
        .done_o      (done_o),
        .rsp_o       (rsp_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #50 clk_i = ~clk_i;
    end

    // ~~~~~~~~~~~~~~~~~~~~
    // Monitors
    // ~~~~~~~~~~~~~~~~~~~~

    always @(negedge clk_i) begin
        if (rst_i && done_o) begin
            rcv_cnt++;
        end
        if (dut.fifo_full) begin
            saw_full = 1'b1;  // Buffer reached its depth.
        end
    end

    initial begin
        repeat (WD_CYCLES) @(posedge clk_i);
        $display("Timeout: no completion after %0d cycles, the DUT appears hung", WD_CYCLES);
        $display(">>> FAIL");
        $finish;
    end

    // ~~~~~~~~~~~~~~~~~~~~
    // Bus tasks
    // ~~~~~~~~~~~~~~~~~~~~

    // Strobes every cycle until ready_o takes it.
    task automatic send_req(input div_op_e op, input logic [DIV_XLEN-1:0] a,
                            input logic [DIV_XLEN-1:0] b);
        div_req_t req;
        logic     taken;
        req.op       = op;
        req.dividend = a;
        req.divisor  = b;
        req.tag      = next_tag;
        taken        = 1'b0;
        while (!taken) begin
            @(posedge clk_i);
            req_valid_i <= 1'b1;
            req_i       <= req;
            @(negedge clk_i);
            taken = ready_o;
            if (!taken) begin
                ignored_cnt++;
            end
        end
        sent_cnt++;
        next_tag++;
    endtask

    task automatic release_bus();
        @(posedge clk_i);
        req_valid_i <= 1'b0;
    endtask

    task automatic wait_drained();
        while (rcv_cnt < sent_cnt) begin
            @(posedge clk_i);
        end
    endtask

    task automatic run_alone(input div_op_e op, input logic [DIV_XLEN-1:0] a,
                             input logic [DIV_XLEN-1:0] b);
        send_req(op, a, b);
        release_bus();
        wait_drained();
        @(posedge clk_i);
    endtask

    // ~~~~~~~~~~~~~~~~~~~~
    // Stimulus
    // ~~~~~~~~~~~~~~~~~~~~

    initial begin
        logic [DIV_XLEN-1:0] a;
        logic [DIV_XLEN-1:0] b;
        div_op_e             op;

        seed        = 32'h50dbd949;
        rst_i       = 1'b0;
        req_valid_i = 1'b0;
        req_i       = '0;
        next_tag    = '0;
        repeat (3) @(posedge clk_i);
        rst_i <= 1'b1;
        @(posedge clk_i);

        // Sign combinations, 20 and 3.
        run_alone(DIV_OP_DIV, 32'd20, 32'd3);
        run_alone(DIV_OP_DIV, 32'hFFFF_FFEC, 32'd3);
        run_alone(DIV_OP_DIV, 32'd20, 32'hFFFF_FFFD);
        run_alone(DIV_OP_DIV, 32'hFFFF_FFEC, 32'hFFFF_FFFD);
        run_alone(DIV_OP_REM, 32'd20, 32'd3);
        run_alone(DIV_OP_REM, 32'hFFFF_FFEC, 32'd3);
        run_alone(DIV_OP_REM, 32'd20, 32'hFFFF_FFFD);
        run_alone(DIV_OP_REM, 32'hFFFF_FFEC, 32'hFFFF_FFFD);
        run_alone(DIV_OP_DIVU, 32'd20, 32'd3);
        run_alone(DIV_OP_DIVU, 32'hFFFF_FFF0, 32'd7);
        run_alone(DIV_OP_REMU, 32'd20, 32'd3);
        run_alone(DIV_OP_REMU, 32'hFFFF_FFF0, 32'd7);

        // Divide by zero and signed overflow.
        run_alone(DIV_OP_DIV, 32'hFFFF_FFF9, 32'd0);
        run_alone(DIV_OP_DIVU, 32'hFFFF_FFF9, 32'd0);
        run_alone(DIV_OP_REM, 32'hFFFF_FFF9, 32'd0);
        run_alone(DIV_OP_REMU, 32'hFFFF_FFF9, 32'd0);
        run_alone(DIV_OP_DIV, DIV_INT_MIN, DIV_ALL_ONES);
        run_alone(DIV_OP_REM, DIV_INT_MIN, DIV_ALL_ONES);
        run_alone(DIV_OP_DIVU, DIV_INT_MIN, DIV_ALL_ONES);  // Not special when unsigned.

        // Back-to-back burst, overruns the buffer.
        for (int i = 0; i < N_BURST; i++) begin
            send_req(i[0] ? DIV_OP_REM : DIV_OP_DIV, 32'h7654_3210 - i, 32'd9 + i);
        end
        release_bus();
        wait_drained();

        for (int i = 0; i < N_RANDOM; i++) begin
            op = div_op_e'(2'($random(seed)));
            a  = $random(seed);
            b  = $random(seed);
            if (i % 3 == 0) begin
                b = b & 32'h0000_00FF;  // Small divisors.
            end
            send_req(op, a, b);
        end
        release_bus();
        wait_drained();
        repeat (4) @(posedge clk_i);

        if (rcv_cnt != sent_cnt) begin
            $display("ERR %0t: %0d responses for %0d accepted requests", $time,
                     rcv_cnt, sent_cnt);
            cnt_err++;
        end
        if (ignored_cnt == 0 || !saw_full) begin
            $display("Back-pressure never occurred: the command buffer did not fill up");
            cnt_err++;
        end
        $display("Errors: %0d from assertions, %0d from counts", dut.u_sva.err_cnt, cnt_err);
        if (dut.u_sva.err_cnt == 0 && cnt_err == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

// ==== filelist.f ====
div_pkg.sv
div_operand_prep.sv
div_cmd_fifo.sv
div_nonrestoring_core.sv
div_unit_top.sv
div_unit_sva.sv
tb_div_unit.sv
